// File: list.f
hdl/isa_pkg.sv
hdl/sb_pkg.sv
hdl/sb_entry_table.sv
hdl/sb_clobber_map.sv
hdl/sb_operand_fwd.sv
hdl/sb_top.sv
bench/sb_sva.sv
bench/sb_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the scoreboard testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f list.f --top-module sb_tb -o sb_sim \
  && ./obj_dir/sb_sim | tee /dev/stderr | grep -qx "All checks passed" \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }

// File: bench/sb_tb.sv
// drives u_dut one step at a time; 8 entries, 3 write-back lanes, only one lane active per step
module sb_tb;
  import isa_pkg::*;
  import sb_pkg::*;

  localparam int unsigned NR_ENTRIES  = 8;
  localparam int unsigned NR_WB_PORTS = 3;
  localparam int unsigned TRANS_ID_W  = $clog2(NR_ENTRIES);
  localparam int COMMIT_TIMEOUT = 20;

  // step operations
  localparam int OP_ISSUE = 0, OP_WB = 1, OP_COMMIT = 2, OP_READ = 3, OP_FLUSH = 4;
  localparam int OP_IDLE = 5, OP_CLOB = 6, OP_HEAD = 7, OP_FULL = 8, OP_BRANCH = 9;

  logic clk_i, rst_ni, flush_i, unresolved_branch_i, sb_full_o;
  logic decoded_valid_i, decoded_ack_o, issue_valid_o, issue_ack_i;
  reg_addr_t decoded_rd_i, issue_rd_o, commit_rd_o, rs1_i, rs2_i;
  fu_t decoded_fu_i, issue_fu_o, commit_fu_o;
  logic [TRANS_ID_W-1:0] issue_trans_id_o, commit_trans_id_o;
  logic [NR_WB_PORTS-1:0] wb_valid_i;
  logic [NR_WB_PORTS-1:0][TRANS_ID_W-1:0] wb_trans_id_i;
  xlen_t [NR_WB_PORTS-1:0] wb_data_i;
  logic commit_valid_o, commit_ack_i, rs1_valid_o, rs2_valid_o;
  xlen_t commit_result_o, rs1_o, rs2_o;
  fu_t [NUM_GPR-1:0] rd_clobber_o;

  // stimulus table, one entry per step
  // issue: a=rd b=fu c=id | wb: a=id b=lane c=rs d=data | commit: a=id b=rd c=chk d=result
  // read: a=rs b=valid d=data | head: a=id b=valid | full: a=full
  string       step_name[$];
  int          step_op[$], step_a[$], step_b[$], step_c[$];
  logic [63:0] step_d[$];

  // expected clobber map, kept from the issue/commit/flush rules
  int    exp_clob[NUM_GPR];
  // fu recorded per transaction ID at issue
  int    exp_fu[NR_ENTRIES];
  xlen_t wb_word[6];
  logic [63:0] rng;
  int    n_checks, n_errs, n_bad_steps, step_errs;
  bit    timed_out;

  sb_top #(
    .NR_ENTRIES  (NR_ENTRIES),
    .NR_WB_PORTS (NR_WB_PORTS)
  ) u_dut (.*);

  bind sb_top sb_sva #(
    .NR_WB_PORTS (NR_WB_PORTS),
    .TRANS_ID_W  (TRANS_ID_W)
  ) u_sva (.*);

  function automatic logic [63:0] lcg_next(input logic [63:0] s);
    return s * 64'd6364136223846793005 + 64'd1442695040888963407;
  endfunction

  task automatic add_step(input string name, input int op, input int a, input int b,
                          input int c, input logic [63:0] d);
    step_name.push_back(name);
    step_op.push_back(op);
    step_a.push_back(a);
    step_b.push_back(b);
    step_c.push_back(c);
    step_d.push_back(d);
  endtask

  task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
    n_checks++;
    if (exp !== act) begin
      $display("FAIL %s expected %0h actual %0h", what, exp, act);
      step_errs++;
    end
  endtask

  // ------------------------------------------------------------------------
  // clock and stimulus table
  // ------------------------------------------------------------------------

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  task automatic build_table();
    for (int k = 0; k < 6; k++) begin
      rng = lcg_next(rng);
      wb_word[k] = rng;
    end
    add_step("issue x1 alu", OP_ISSUE, 1, int'(FU_ALU), 0, '0);
    add_step("issue x2 load", OP_ISSUE, 2, int'(FU_LOAD), 1, '0);
    add_step("issue x3 mult", OP_ISSUE, 3, int'(FU_MULT), 2, '0);
    add_step("clobber after issue", OP_CLOB, 0, 0, 0, '0);
    add_step("read x2 pending", OP_READ, 2, 0, 0, '0);
    add_step("wb id1 lane1 fwd", OP_WB, 1, 1, 2, wb_word[1]);
    add_step("read x2 stored", OP_READ, 2, 1, 0, wb_word[1]);
    add_step("wb id1 lane2 beats stored", OP_WB, 1, 2, 2, wb_word[2]);
    add_step("wb id0 lane0", OP_WB, 0, 0, 1, wb_word[0]);
    add_step("commit id0", OP_COMMIT, 0, 1, 1, wb_word[0]);
    add_step("commit id1", OP_COMMIT, 1, 2, 1, wb_word[2]);
    add_step("clobber after commits", OP_CLOB, 0, 0, 0, '0);
    add_step("wb id2 lane0", OP_WB, 2, 0, 3, wb_word[3]);
    add_step("commit id2", OP_COMMIT, 2, 3, 1, wb_word[3]);
    add_step("issue x7 none", OP_ISSUE, 7, int'(FU_NONE), 3, '0);
    add_step("commit none id3", OP_COMMIT, 3, 7, 0, '0);
    add_step("head moved to id4", OP_HEAD, 4, 0, 0, '0);
    add_step("clobber empty", OP_CLOB, 0, 0, 0, '0);
    for (int k = 0; k < NR_ENTRIES - 1; k++) begin
      add_step($sformatf("fill x%0d", 8 + k), OP_ISSUE, 8 + k, int'(FU_ALU), (4 + k) % 8, '0);
    end
    add_step("full backpressure", OP_FULL, 1, 0, 0, '0);
    add_step("wb id4 lane0", OP_WB, 4, 0, 8, wb_word[4]);
    add_step("head valid before flush", OP_HEAD, 4, 1, 0, '0);
    add_step("flush", OP_FLUSH, 0, 0, 0, '0);
    add_step("not full after flush", OP_FULL, 0, 0, 0, '0);
    add_step("clobber after flush", OP_CLOB, 0, 0, 0, '0);
    add_step("head after flush", OP_HEAD, 0, 0, 0, '0);
    add_step("issue x5 after flush", OP_ISSUE, 5, int'(FU_LOAD), 0, '0);
    add_step("issue x0 alu", OP_ISSUE, 0, int'(FU_ALU), 1, '0);
    add_step("clobber with x0 pending", OP_CLOB, 0, 0, 0, '0);
    add_step("wb id1 lane0 to x0", OP_WB, 1, 0, 0, wb_word[5]);
    add_step("read x0", OP_READ, 0, 0, 0, '0);
    add_step("unresolved branch", OP_BRANCH, 0, 0, 0, '0);
    add_step("idle", OP_IDLE, 0, 0, 0, '0);
  endtask

  // ------------------------------------------------------------------------
  // one step: drive on the rising edge, check at the falling edge
  // ------------------------------------------------------------------------

  task automatic run_step(input int i);
    int    wait_cnt;
    string nm;
    nm = step_name[i];
    step_errs = 0;
    @(posedge clk_i);
    decoded_valid_i <= 1'b0;
    issue_ack_i <= 1'b0;
    commit_ack_i <= 1'b0;
    flush_i <= 1'b0;
    unresolved_branch_i <= 1'b0;
    wb_valid_i <= '0;
    case (step_op[i])
      OP_ISSUE: begin
        decoded_valid_i <= 1'b1;
        issue_ack_i <= 1'b1;
        decoded_rd_i <= reg_addr_t'(step_a[i]);
        decoded_fu_i <= fu_t'(step_b[i]);
      end
      OP_WB: begin
        wb_valid_i[step_b[i]] <= 1'b1;
        wb_trans_id_i[step_b[i]] <= TRANS_ID_W'(step_a[i]);
        wb_data_i[step_b[i]] <= step_d[i];
        rs1_i <= reg_addr_t'(step_c[i]);
      end
      OP_READ: begin
        rs1_i <= reg_addr_t'(step_a[i]);
        rs2_i <= reg_addr_t'(step_a[i]);
      end
      OP_FLUSH: flush_i <= 1'b1;
      OP_FULL, OP_BRANCH: begin
        // ack held low, so nothing is written
        decoded_valid_i <= 1'b1;
        unresolved_branch_i <= (step_op[i] == OP_BRANCH);
      end
      default: ;
    endcase
    @(negedge clk_i);
    case (step_op[i])
      OP_ISSUE: begin
        compare({nm, " issue_valid"}, 64'd1, 64'(issue_valid_o));
        compare({nm, " decoded_ack"}, 64'd1, 64'(decoded_ack_o));
        compare({nm, " trans_id"}, 64'(step_c[i]), 64'(issue_trans_id_o));
        compare({nm, " issue_rd"}, 64'(step_a[i]), 64'(issue_rd_o));
        compare({nm, " issue_fu"}, 64'(step_b[i]), 64'(issue_fu_o));
        exp_fu[step_c[i]] = step_b[i];
        if (step_a[i] != 0) exp_clob[step_a[i]] = step_b[i];
      end
      OP_WB: begin
        // x0 never forwards, even from a matching lane
        compare({nm, " rs1_valid"}, 64'(step_c[i] != 0), 64'(rs1_valid_o));
        if (step_c[i] != 0) compare({nm, " rs1"}, step_d[i], rs1_o);
      end
      OP_READ: begin
        compare({nm, " rs1_valid"}, 64'(step_b[i]), 64'(rs1_valid_o));
        compare({nm, " rs2_valid"}, 64'(step_b[i]), 64'(rs2_valid_o));
        if (step_b[i] != 0) compare({nm, " rs1"}, step_d[i], rs1_o);
        if (step_b[i] != 0) compare({nm, " rs2"}, step_d[i], rs2_o);
      end
      OP_COMMIT: begin
        wait_cnt = 0;
        while (!commit_valid_o && wait_cnt < COMMIT_TIMEOUT) begin
          @(negedge clk_i);
          wait_cnt++;
        end
        if (!commit_valid_o) begin
          $display("step %s timed out, commit_valid_o never went high", nm);
          step_errs++;
          timed_out = 1'b1;
        end else begin
          compare({nm, " trans_id"}, 64'(step_a[i]), 64'(commit_trans_id_o));
          compare({nm, " rd"}, 64'(step_b[i]), 64'(commit_rd_o));
          compare({nm, " fu"}, 64'(exp_fu[step_a[i]]), 64'(commit_fu_o));
          if (step_c[i] != 0) compare({nm, " result"}, step_d[i], commit_result_o);
          exp_clob[step_b[i]] = int'(FU_NONE);
          @(posedge clk_i);
          commit_ack_i <= 1'b1;
        end
      end
      OP_CLOB: begin
        for (int r = 0; r < NUM_GPR; r++) begin
          compare($sformatf("%s x%0d", nm, r), 64'(exp_clob[r]), 64'(rd_clobber_o[r]));
        end
      end
      OP_HEAD: begin
        compare({nm, " commit_valid"}, 64'(step_b[i]), 64'(commit_valid_o));
        compare({nm, " commit_trans_id"}, 64'(step_a[i]), 64'(commit_trans_id_o));
      end
      OP_FULL: begin
        compare({nm, " sb_full"}, 64'(step_a[i]), 64'(sb_full_o));
        compare({nm, " issue_valid"}, 64'(step_a[i] == 0), 64'(issue_valid_o));
        compare({nm, " decoded_ack"}, 64'd0, 64'(decoded_ack_o));
      end
      OP_BRANCH: compare({nm, " issue_valid"}, 64'd0, 64'(issue_valid_o));
      OP_FLUSH: begin
        for (int r = 0; r < NUM_GPR; r++) exp_clob[r] = int'(FU_NONE);
      end
      default: ;
    endcase
    n_errs += step_errs;
    if (step_errs != 0) n_bad_steps++;
    $display("%s %s", (step_errs == 0) ? "ok" : "bad", nm);
  endtask

  initial begin
    rst_ni = 1'b0;
    flush_i = 1'b0;
    unresolved_branch_i = 1'b0;
    decoded_valid_i = 1'b0;
    decoded_rd_i = '0;
    decoded_fu_i = FU_NONE;
    issue_ack_i = 1'b0;
    wb_valid_i = '0;
    wb_trans_id_i = '0;
    wb_data_i = '0;
    commit_ack_i = 1'b0;
    rs1_i = '0;
    rs2_i = '0;
    rng = 64'd92;
    n_checks = 0;
    n_errs = 0;
    n_bad_steps = 0;
    timed_out = 1'b0;
    for (int r = 0; r < NUM_GPR; r++) exp_clob[r] = int'(FU_NONE);
    for (int e = 0; e < NR_ENTRIES; e++) exp_fu[e] = int'(FU_NONE);
    build_table();
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    // a timed-out wait ends the step loop early
    for (int i = 0; i < step_op.size() && !timed_out; i++) begin
      run_step(i);
    end
    $display("steps %0d, failing steps %0d, checks %0d, mismatches %0d",
             step_op.size(), n_bad_steps, n_checks, n_errs);
    if (n_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: bench/sb_sva.sv
// port rules of the scoreboard top level, checked only while out of reset
module sb_sva #(
  parameter int unsigned NR_WB_PORTS = sb_pkg::DEF_NR_WB_PORTS,
  parameter int unsigned TRANS_ID_W  = $clog2(sb_pkg::DEF_NR_ENTRIES)
) (
  input logic                                   clk_i,
  input logic                                   rst_ni,
  input logic                                   issue_ack_i,
  input logic                                   issue_valid_o,
  input logic                                   commit_ack_i,
  input logic                                   commit_valid_o,
  input logic [NR_WB_PORTS-1:0]                 wb_valid_i,
  input logic [NR_WB_PORTS-1:0][TRANS_ID_W-1:0] wb_trans_id_i,
  input sb_pkg::fu_t [isa_pkg::NUM_GPR-1:0]     rd_clobber_o
);
  import sb_pkg::*;

  // x0 never has a pending writer
  assert property (@(posedge clk_i) disable iff (!rst_ni) rd_clobber_o[0] == FU_NONE)
    else $error("x0 shows a pending writer in the clobber map");

  // commit stage only acks a valid head
  assert property (@(posedge clk_i) disable iff (!rst_ni) commit_ack_i |-> commit_valid_o)
    else $error("commit ack without a valid head entry");

  // issue stage only acks a valid instruction
  assert property (@(posedge clk_i) disable iff (!rst_ni) issue_ack_i |-> issue_valid_o)
    else $error("issue ack without a valid instruction");

  // each pair of lanes, at most one result per ID and cycle
  for (genvar la = 0; la < NR_WB_PORTS; la++) begin : g_lane_a
    for (genvar lb = la + 1; lb < NR_WB_PORTS; lb++) begin : g_lane_b
      assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(wb_valid_i[la] && wb_valid_i[lb] && (wb_trans_id_i[la] == wb_trans_id_i[lb])))
        else $error("write-back lanes %0d and %0d carry the same ID", la, lb);
    end
  end

endmodule

// File: hdl/sb_top.sv
// NR_ENTRIES must be a power of two and holds at most NR_ENTRIES-1 instructions; one commit port
module sb_top #(
  parameter int unsigned NR_ENTRIES  = sb_pkg::DEF_NR_ENTRIES,
  parameter int unsigned NR_WB_PORTS = sb_pkg::DEF_NR_WB_PORTS,
  localparam int unsigned TRANS_ID_W = $clog2(NR_ENTRIES)
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  input  logic                                   unresolved_branch_i,
  output logic                                   sb_full_o,
  // decode / issue handshake
  input  logic                                   decoded_valid_i,
  input  isa_pkg::reg_addr_t                     decoded_rd_i,
  input  sb_pkg::fu_t                            decoded_fu_i,
  output logic                                   decoded_ack_o,
  output logic                                   issue_valid_o,
  output logic [TRANS_ID_W-1:0]                  issue_trans_id_o,
  output isa_pkg::reg_addr_t                     issue_rd_o,
  output sb_pkg::fu_t                            issue_fu_o,
  input  logic                                   issue_ack_i,
  // write-back lanes
  input  logic [NR_WB_PORTS-1:0]                 wb_valid_i,
  input  logic [NR_WB_PORTS-1:0][TRANS_ID_W-1:0] wb_trans_id_i,
  input  isa_pkg::xlen_t [NR_WB_PORTS-1:0]       wb_data_i,
  // commit port
  output logic                                   commit_valid_o,
  output logic [TRANS_ID_W-1:0]                  commit_trans_id_o,
  output isa_pkg::reg_addr_t                     commit_rd_o,
  output sb_pkg::fu_t                            commit_fu_o,
  output isa_pkg::xlen_t                         commit_result_o,
  input  logic                                   commit_ack_i,
  // clobber map to issue stage
  output sb_pkg::fu_t [isa_pkg::NUM_GPR-1:0]     rd_clobber_o,
  // operand read
  input  isa_pkg::reg_addr_t                     rs1_i,
  output isa_pkg::xlen_t                         rs1_o,
  output logic                                   rs1_valid_o,
  input  isa_pkg::reg_addr_t                     rs2_i,
  output isa_pkg::xlen_t                         rs2_o,
  output logic                                   rs2_valid_o
);
  import isa_pkg::*;
  import sb_pkg::*;

  // per-entry state published by the table
  logic  [NR_ENTRIES-1:0] entry_issued;
  logic  [NR_ENTRIES-1:0] entry_done;
  reg_addr_t [NR_ENTRIES-1:0] entry_rd;
  fu_t   [NR_ENTRIES-1:0] entry_fu;
  xlen_t [NR_ENTRIES-1:0] entry_result;

  // storage, pointers and handshakes
  sb_entry_table #(
    .NR_ENTRIES  (NR_ENTRIES),
    .NR_WB_PORTS (NR_WB_PORTS)
  ) u_table (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .unresolved_branch_i (unresolved_branch_i),
    .sb_full_o           (sb_full_o),
    .decoded_valid_i     (decoded_valid_i),
    .decoded_rd_i        (decoded_rd_i),
    .decoded_fu_i        (decoded_fu_i),
    .decoded_ack_o       (decoded_ack_o),
    .issue_valid_o       (issue_valid_o),
    .issue_trans_id_o    (issue_trans_id_o),
    .issue_rd_o          (issue_rd_o),
    .issue_fu_o          (issue_fu_o),
    .issue_ack_i         (issue_ack_i),
    .wb_valid_i          (wb_valid_i),
    .wb_trans_id_i       (wb_trans_id_i),
    .wb_data_i           (wb_data_i),
    .commit_valid_o      (commit_valid_o),
    .commit_trans_id_o   (commit_trans_id_o),
    .commit_rd_o         (commit_rd_o),
    .commit_fu_o         (commit_fu_o),
    .commit_result_o     (commit_result_o),
    .commit_ack_i        (commit_ack_i),
    .entry_issued_o      (entry_issued),
    .entry_done_o        (entry_done),
    .entry_rd_o          (entry_rd),
    .entry_fu_o          (entry_fu),
    .entry_result_o      (entry_result)
  );

  // pending writer per register
  sb_clobber_map #(
    .NR_ENTRIES (NR_ENTRIES)
  ) u_clobber (
    .entry_issued_i (entry_issued),
    .entry_rd_i     (entry_rd),
    .entry_fu_i     (entry_fu),
    .rd_clobber_o   (rd_clobber_o)
  );

  // bypass network for rs1/rs2
  sb_operand_fwd #(
    .NR_ENTRIES  (NR_ENTRIES),
    .NR_WB_PORTS (NR_WB_PORTS)
  ) u_fwd (
    .rs1_i          (rs1_i),
    .rs2_i          (rs2_i),
    .wb_valid_i     (wb_valid_i),
    .wb_trans_id_i  (wb_trans_id_i),
    .wb_data_i      (wb_data_i),
    .entry_issued_i (entry_issued),
    .entry_done_i   (entry_done),
    .entry_rd_i     (entry_rd),
    .entry_result_i (entry_result),
    .rs1_o          (rs1_o),
    .rs1_valid_o    (rs1_valid_o),
    .rs2_o          (rs2_o),
    .rs2_valid_o    (rs2_valid_o)
  );

endmodule

// File: hdl/sb_operand_fwd.sv
// combinational; x0 is never forwarded, and a lane only counts when its target slot is issued
module sb_operand_fwd #(
  parameter int unsigned NR_ENTRIES  = sb_pkg::DEF_NR_ENTRIES,
  parameter int unsigned NR_WB_PORTS = sb_pkg::DEF_NR_WB_PORTS,
  localparam int unsigned TRANS_ID_W = $clog2(NR_ENTRIES)
) (
  input  isa_pkg::reg_addr_t                     rs1_i,
  input  isa_pkg::reg_addr_t                     rs2_i,
  input  logic [NR_WB_PORTS-1:0]                 wb_valid_i,
  input  logic [NR_WB_PORTS-1:0][TRANS_ID_W-1:0] wb_trans_id_i,
  input  isa_pkg::xlen_t [NR_WB_PORTS-1:0]       wb_data_i,
  input  logic [NR_ENTRIES-1:0]                  entry_issued_i,
  input  logic [NR_ENTRIES-1:0]                  entry_done_i,
  input  isa_pkg::reg_addr_t [NR_ENTRIES-1:0]    entry_rd_i,
  input  isa_pkg::xlen_t [NR_ENTRIES-1:0]        entry_result_i,
  output isa_pkg::xlen_t                         rs1_o,
  output logic                                   rs1_valid_o,
  output isa_pkg::xlen_t                         rs2_o,
  output logic                                   rs2_valid_o
);
  import isa_pkg::*;
  import sb_pkg::*;

  // ------------------------------------------------------------------------
  // source selection, shared by both operands
  // ------------------------------------------------------------------------

  // returns {valid, data}
  // write-back lanes first, then finished slots, lowest index wins in each
  function automatic logic [XLEN:0] fwd_pick(input reg_addr_t rs);
    logic  hit;
    xlen_t data;

    hit  = 1'b0;
    data = '0;

    // results on the buses this cycle are the freshest
    for (int unsigned k = 0; k < NR_WB_PORTS; k++) begin
      if (!hit && wb_valid_i[k] && entry_issued_i[wb_trans_id_i[k]]
          && (entry_rd_i[wb_trans_id_i[k]] == rs)) begin
        hit  = 1'b1;
        data = wb_data_i[k];
      end
    end

    // results already stored but not yet committed
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      if (!hit && entry_issued_i[i] && entry_done_i[i] && (entry_rd_i[i] == rs)) begin
        hit  = 1'b1;
        data = entry_result_i[i];
      end
    end

    // x0 always comes from the register file
    return {hit & (rs != '0), data};
  endfunction

  // rs1 port
  always_comb begin
    {rs1_valid_o, rs1_o} = fwd_pick(rs1_i);
  end

  // rs2 port
  always_comb begin
    {rs2_valid_o, rs2_o} = fwd_pick(rs2_i);
  end

endmodule

// File: hdl/sb_clobber_map.sv
// combinational; assumes at most one in-flight writer per register, else the lowest slot wins
module sb_clobber_map #(
  parameter int unsigned NR_ENTRIES = sb_pkg::DEF_NR_ENTRIES
) (
  input  logic [NR_ENTRIES-1:0]                entry_issued_i,
  input  isa_pkg::reg_addr_t [NR_ENTRIES-1:0]  entry_rd_i,
  input  sb_pkg::fu_t [NR_ENTRIES-1:0]         entry_fu_i,
  output sb_pkg::fu_t [isa_pkg::NUM_GPR-1:0]   rd_clobber_o
);
  import isa_pkg::*;
  import sb_pkg::*;

  // ------------------------------------------------------------------------
  // per-register writer selection
  // ------------------------------------------------------------------------

  // fixed priority, lowest slot index wins
  always_comb begin
    logic hit;

    for (int unsigned r = 0; r < NUM_GPR; r++) begin
      hit             = 1'b0;
      rd_clobber_o[r] = FU_NONE;
      // scan slots in ascending order, first issued match sticks
      for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
        if (!hit && entry_issued_i[i] && (entry_rd_i[i] == reg_addr_t'(r))) begin
          hit             = 1'b1;
          rd_clobber_o[r] = entry_fu_i[i];
        end
      end
    end

    // x0 is hardwired, never pending
    rd_clobber_o[0] = FU_NONE;
  end

endmodule

// File: hdl/sb_entry_table.sv
// power-of-two depth only; full at NR_ENTRIES-1 entries; write-back to a non-issued slot is dropped
module sb_entry_table #(
  parameter int unsigned NR_ENTRIES  = sb_pkg::DEF_NR_ENTRIES,
  parameter int unsigned NR_WB_PORTS = sb_pkg::DEF_NR_WB_PORTS,
  localparam int unsigned TRANS_ID_W = $clog2(NR_ENTRIES)
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   flush_i,
  input  logic                                   unresolved_branch_i,
  output logic                                   sb_full_o,
  input  logic                                   decoded_valid_i,
  input  isa_pkg::reg_addr_t                     decoded_rd_i,
  input  sb_pkg::fu_t                            decoded_fu_i,
  output logic                                   decoded_ack_o,
  output logic                                   issue_valid_o,
  output logic [TRANS_ID_W-1:0]                  issue_trans_id_o,
  output isa_pkg::reg_addr_t                     issue_rd_o,
  output sb_pkg::fu_t                            issue_fu_o,
  input  logic                                   issue_ack_i,
  input  logic [NR_WB_PORTS-1:0]                 wb_valid_i,
  input  logic [NR_WB_PORTS-1:0][TRANS_ID_W-1:0] wb_trans_id_i,
  input  isa_pkg::xlen_t [NR_WB_PORTS-1:0]       wb_data_i,
  output logic                                   commit_valid_o,
  output logic [TRANS_ID_W-1:0]                  commit_trans_id_o,
  output isa_pkg::reg_addr_t                     commit_rd_o,
  output sb_pkg::fu_t                            commit_fu_o,
  output isa_pkg::xlen_t                         commit_result_o,
  input  logic                                   commit_ack_i,
  output logic [NR_ENTRIES-1:0]                  entry_issued_o,
  output logic [NR_ENTRIES-1:0]                  entry_done_o,
  output isa_pkg::reg_addr_t [NR_ENTRIES-1:0]    entry_rd_o,
  output sb_pkg::fu_t [NR_ENTRIES-1:0]           entry_fu_o,
  output isa_pkg::xlen_t [NR_ENTRIES-1:0]        entry_result_o
);
  import isa_pkg::*;
  import sb_pkg::*;

  // slot control bits
  logic [NR_ENTRIES-1:0] issued_q, issued_d;
  logic [NR_ENTRIES-1:0] done_q, done_d;
  // slot payload
  reg_addr_t [NR_ENTRIES-1:0] rd_q;
  fu_t       [NR_ENTRIES-1:0] fu_q;
  xlen_t     [NR_ENTRIES-1:0] result_q, result_d;

  // circular pointers and occupancy
  logic [TRANS_ID_W-1:0] issue_ptr_q, issue_ptr_d;
  logic [TRANS_ID_W-1:0] commit_ptr_q, commit_ptr_d;
  logic [TRANS_ID_W-1:0] cnt_q, cnt_d;

  logic full;
  logic issue_en;
  logic commit_en;

  // ------------------------------------------------------------------------
  // handshakes
  // ------------------------------------------------------------------------

  // one slot is kept free, so the count never wraps
  assign full      = (cnt_q == TRANS_ID_W'(NR_ENTRIES - 1));
  assign sb_full_o = full;

  // no new issue behind an unresolved branch, ack only depends on room
  assign issue_valid_o = decoded_valid_i & ~unresolved_branch_i & ~full;
  assign decoded_ack_o = issue_ack_i & ~full;
  assign issue_en      = decoded_valid_i & decoded_ack_o;

  // the slot index is the transaction ID
  assign issue_trans_id_o = issue_ptr_q;
  assign issue_rd_o       = decoded_rd_i;
  assign issue_fu_o       = decoded_fu_i;

  // oldest entry, valid once its result is in
  assign commit_valid_o    = issued_q[commit_ptr_q] & done_q[commit_ptr_q];
  assign commit_trans_id_o = commit_ptr_q;
  assign commit_rd_o       = rd_q[commit_ptr_q];
  assign commit_fu_o       = fu_q[commit_ptr_q];
  assign commit_result_o   = result_q[commit_ptr_q];
  // an ack without a valid head is ignored
  assign commit_en         = commit_ack_i & commit_valid_o;

  // ------------------------------------------------------------------------
  // slot next state
  // ------------------------------------------------------------------------

  always_comb begin
    issued_d = issued_q;
    done_d   = done_q;
    result_d = result_q;

    // new entry at the issue pointer, not done yet
    if (issue_en) begin
      issued_d[issue_ptr_q] = 1'b1;
      done_d[issue_ptr_q]   = 1'b0;
    end

    // nothing to wait for on FU_NONE
    for (int unsigned i = 0; i < NR_ENTRIES; i++) begin
      if (issued_q[i] && (fu_q[i] == FU_NONE)) begin
        done_d[i] = 1'b1;
      end
    end

    // results from the functional units, stale IDs are dropped
    for (int unsigned k = 0; k < NR_WB_PORTS; k++) begin
      if (wb_valid_i[k] && issued_q[wb_trans_id_i[k]]) begin
        done_d[wb_trans_id_i[k]]   = 1'b1;
        result_d[wb_trans_id_i[k]] = wb_data_i[k];
      end
    end

    // retire the head
    if (commit_en) begin
      issued_d[commit_ptr_q] = 1'b0;
      done_d[commit_ptr_q]   = 1'b0;
    end

    // flush overrides all of the above
    if (flush_i) begin
      issued_d = '0;
      done_d   = '0;
    end
  end

  assign issue_ptr_d  = flush_i ? '0 : issue_ptr_q + TRANS_ID_W'(issue_en);
  assign commit_ptr_d = flush_i ? '0 : commit_ptr_q + TRANS_ID_W'(commit_en);
  assign cnt_d        = flush_i ? '0 :
                        cnt_q + TRANS_ID_W'(issue_en) - TRANS_ID_W'(commit_en);

  // ------------------------------------------------------------------------
  // registers
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q     <= '0;
      done_q       <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      issued_q     <= issued_d;
      done_q       <= done_d;
      issue_ptr_q  <= issue_ptr_d;
      commit_ptr_q <= commit_ptr_d;
      cnt_q        <= cnt_d;
    end
  end

  // slot payload, rd and fu at issue, results every cycle
  always_ff @(posedge clk_i) begin
    if (issue_en) begin
      rd_q[issue_ptr_q] <= decoded_rd_i;
      fu_q[issue_ptr_q] <= decoded_fu_i;
    end
    result_q <= result_d;
  end

  // per-entry view for clobber map and forwarding
  assign entry_issued_o = issued_q;
  assign entry_done_o   = done_q;
  assign entry_rd_o     = rd_q;
  assign entry_fu_o     = fu_q;
  assign entry_result_o = result_q;

endmodule

// File: hdl/sb_pkg.sv
// scoreboard defaults assume a power-of-two depth; FU_NONE must stay encoded as 0
package sb_pkg;

  // ------------------------------------------------------------------------
  // functional units
  // ------------------------------------------------------------------------

  // which unit produces the result of an instruction
  // FU_NONE means nothing to wait for, result is ready at issue
  typedef enum logic [2:0] {
    FU_NONE  = 3'd0,
    FU_ALU   = 3'd1,
    FU_LOAD  = 3'd2,
    FU_STORE = 3'd3,
    FU_MULT  = 3'd4,
    FU_CSR   = 3'd5
  } fu_t;

  // ------------------------------------------------------------------------
  // default sizes
  // ------------------------------------------------------------------------

  // table depth, power of two; one slot stays free to tell full from empty
  localparam int unsigned DEF_NR_ENTRIES = 8;

  // result buses coming back from the functional units
  localparam int unsigned DEF_NR_WB_PORTS = 3;

endpackage

// File: hdl/isa_pkg.sv
// integer register file only (RV64, 32 GPRs); x0 reads as zero, no FP registers here
package isa_pkg;

  // ------------------------------------------------------------------------
  // register file facts
  // ------------------------------------------------------------------------

  // number of general-purpose registers, x0 included
  localparam int unsigned NUM_GPR = 32;

  // bits needed to name one register
  localparam int unsigned REG_ADDR_W = $clog2(NUM_GPR);

  // data word width of the integer core
  localparam int unsigned XLEN = 64;

  // ------------------------------------------------------------------------
  // vector types with a meaning
  // ------------------------------------------------------------------------

  // register index as found in rd/rs1/rs2 fields
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // one data word, result or operand
  typedef logic [XLEN-1:0] xlen_t;

endpackage
